// File: hw/fetch_pkg.sv
package fetch_pkg;

    localparam int inst_w = 32;
    localparam int words_per_line = 4;
    localparam int line_w = inst_w * words_per_line;
    localparam int line_addr_w = 10;

    // pc field positions
    localparam int sel_lsb = 2;
    localparam int key_lsb = 4;

    typedef logic [31:0] word_t;
    typedef logic [inst_w-1:0] inst_t;
    typedef logic [$clog2(words_per_line)-1:0] word_sel_t;
    typedef logic [line_addr_w-1:0] line_addr_t;

    // word 0 sits in the low bits
    typedef logic [line_w-1:0] line_t;

    typedef struct packed {
        logic       valid;
        line_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t key;
        line_t      data;
    } line_fill_t;

    typedef enum logic [1:0] {
        st_idle,
        st_stream,
        st_hold
    } ctrl_state_t;

endpackage

// File: hw/lane_decode.sv
`timescale 1ns/10ps

module lane_decode import fetch_pkg::*; #(
    parameter int LANES = 2
) (
    input  logic [LANES-1:0] order,
    input  word_t            pc [LANES],
    input  logic [LANES-1:0] hit,
    input  line_t            lines [LANES],
    output line_addr_t       key [LANES],
    output logic [LANES-1:0] done,
    output inst_t            instr [LANES],
    output logic             miss,
    output line_addr_t       miss_addr,
    output logic             last_valid,
    output line_addr_t       last_served
);

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        word_sel_t offset;
        inst_t     words [words_per_line];

        assign key[i] = pc[i][key_lsb +: line_addr_w];
        assign offset = pc[i][sel_lsb +: $bits(word_sel_t)];

        for (genvar w = 0; w < words_per_line; w++) begin : g_word
            assign words[w] = lines[i][w*inst_w +: inst_w];
        end

        assign instr[i] = words[offset];
        assign done[i] = order[i] & hit[i];
    end

    // lowest ordered lane that missed wins
    always_comb begin
        miss = 1'b0;
        miss_addr = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (order[i] && !hit[i]) begin
                miss = 1'b1;
                miss_addr = key[i];
            end
        end
    end

    // highest lane served this cycle
    always_comb begin
        last_valid = 1'b0;
        last_served = '0;
        for (int i = 0; i < LANES; i++) begin
            if (order[i] && hit[i]) begin
                last_valid = 1'b1;
                last_served = key[i];
            end
        end
    end

endmodule

// File: hw/line_cache.sv
`timescale 1ns/10ps

module line_cache import fetch_pkg::*; #(
    parameter int LANES = 2,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  line_fill_t       fill,
    input  line_addr_t       key [LANES],
    output logic [LANES-1:0] hit,
    output line_t            lines [LANES]
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] valid;
    line_addr_t       tags [DEPTH];
    line_t            data [DEPTH];
    logic [ptr_w-1:0] rr_ptr;
    logic             fill_present;
    logic [ptr_w-1:0] fill_slot;

    // every lane against every entry
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            hit[l] = 1'b0;
            lines[l] = '0;
            for (int e = 0; e < DEPTH; e++) begin
                if (valid[e] && tags[e] == key[l]) begin
                    hit[l] = 1'b1;
                    lines[l] = lines[l] | data[e];
                end
            end
        end
    end

    // rewrite in place if the line is already held
    always_comb begin
        fill_present = 1'b0;
        fill_slot = rr_ptr;
        for (int e = 0; e < DEPTH; e++) begin
            if (valid[e] && tags[e] == fill.key) begin
                fill_present = 1'b1;
                fill_slot = ptr_w'(e);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            rr_ptr <= '0;
        end else if (fill.valid) begin
            valid[fill_slot] <= 1'b1;
            if (!fill_present) begin
                if (rr_ptr == ptr_w'(DEPTH - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tags[fill_slot] <= fill.key;
            data[fill_slot] <= fill.data;
        end
    end

endmodule

// File: hw/prefetch_ctrl.sv
`timescale 1ns/10ps

module prefetch_ctrl import fetch_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       miss,
    input  line_addr_t miss_addr,
    input  logic       last_valid,
    input  line_addr_t last_served,
    input  logic       busy_miss,
    input  logic       busy_next,
    output line_addr_t probe_miss,
    output line_addr_t probe_next,
    output mem_req_t   req
);

    ctrl_state_t state;
    ctrl_state_t state_d;
    line_addr_t  last_q;
    logic        new_line;
    logic        take_miss;
    logic        take_next;

    assign probe_miss = miss_addr;
    assign probe_next = last_q + 1'b1;

    // any served line counts as new when coming out of idle
    assign new_line = last_valid && (state == st_idle || last_served != last_q);

    // refill beats prefetch
    assign take_miss = miss && !busy_miss;
    assign take_next = (state == st_stream) && !take_miss && !busy_next;

    always_comb begin
        state_d = state;
        case (state)
            st_idle: begin
                if (new_line) state_d = st_stream;
            end
            st_stream: begin
                // next line requested, or already on its way
                if (!new_line && (take_next || busy_next)) state_d = st_hold;
            end
            st_hold: begin
                if (new_line) state_d = st_stream;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            last_q <= '0;
            req.valid <= 1'b0;
        end else begin
            state <= state_d;
            if (last_valid) last_q <= last_served;
            req.valid <= take_miss || take_next;
        end
        req.addr <= take_miss ? miss_addr : probe_next;
    end

endmodule

// File: hw/inflight_window.sv
`timescale 1ns/10ps

module inflight_window import fetch_pkg::*; #(
    parameter int MEM_LATENCY = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  mem_req_t   req,
    input  line_addr_t probe_miss,
    input  line_addr_t probe_next,
    output logic       busy_miss,
    output logic       busy_next
);

    localparam int win_len = MEM_LATENCY + 2;

    // the live request is the first slot, the rest are aged copies
    mem_req_t aged [win_len-1];

    always_ff @(posedge clk) begin
        aged[0].addr <= req.addr;
        for (int k = 1; k < win_len - 1; k++) begin
            aged[k].addr <= aged[k-1].addr;
        end
        if (reset) begin
            for (int k = 0; k < win_len - 1; k++) begin
                aged[k].valid <= 1'b0;
            end
        end else begin
            aged[0].valid <= req.valid;
            for (int k = 1; k < win_len - 1; k++) begin
                aged[k].valid <= aged[k-1].valid;
            end
        end
    end

    always_comb begin
        busy_miss = req.valid && req.addr == probe_miss;
        busy_next = req.valid && req.addr == probe_next;
        for (int k = 0; k < win_len - 1; k++) begin
            busy_miss = busy_miss | (aged[k].valid && aged[k].addr == probe_miss);
            busy_next = busy_next | (aged[k].valid && aged[k].addr == probe_next);
        end
    end

endmodule

// File: hw/mem_access_pipe.sv
`timescale 1ns/10ps

module mem_access_pipe import fetch_pkg::*; #(
    parameter int MEM_LATENCY = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  mem_req_t   req,
    output logic       mem_read,
    output line_addr_t mem_addr,
    input  line_t      mem_line,
    output line_fill_t fill
);

    // tracks each read until its data comes back
    mem_req_t stage [MEM_LATENCY];

    assign mem_read = req.valid;
    assign mem_addr = req.addr;

    always_ff @(posedge clk) begin
        stage[0].addr <= req.addr;
        for (int k = 1; k < MEM_LATENCY; k++) begin
            stage[k].addr <= stage[k-1].addr;
        end
        if (reset) begin
            for (int k = 0; k < MEM_LATENCY; k++) begin
                stage[k].valid <= 1'b0;
            end
        end else begin
            stage[0].valid <= req.valid;
            for (int k = 1; k < MEM_LATENCY; k++) begin
                stage[k].valid <= stage[k-1].valid;
            end
        end
    end

    // mem_line lines up with the last stage
    always_ff @(posedge clk) begin
        if (reset) begin
            fill.valid <= 1'b0;
        end else begin
            fill.valid <= stage[MEM_LATENCY-1].valid;
        end
        fill.key <= stage[MEM_LATENCY-1].addr;
        fill.data <= mem_line;
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; #(
    parameter int LANES = 2,
    parameter int DEPTH = 8,
    parameter int MEM_LATENCY = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [LANES-1:0] order,
    input  word_t            pc [LANES],
    output logic [LANES-1:0] done,
    output inst_t            instr [LANES],
    output logic             mem_read,
    output line_addr_t       mem_addr,
    input  line_t            mem_line
);

    line_addr_t       key [LANES];
    logic [LANES-1:0] hit;
    line_t            lines [LANES];
    logic             miss;
    line_addr_t       miss_addr;
    logic             last_valid;
    line_addr_t       last_served;
    line_addr_t       probe_miss;
    line_addr_t       probe_next;
    logic             busy_miss;
    logic             busy_next;
    mem_req_t         req;
    line_fill_t       fill;

    lane_decode #(
        .LANES(LANES)
    ) decode_i (
        .order(order),
        .pc(pc),
        .hit(hit),
        .lines(lines),
        .key(key),
        .done(done),
        .instr(instr),
        .miss(miss),
        .miss_addr(miss_addr),
        .last_valid(last_valid),
        .last_served(last_served)
    );

    line_cache #(
        .LANES(LANES),
        .DEPTH(DEPTH)
    ) cache_i (
        .clk(clk),
        .reset(reset),
        .fill(fill),
        .key(key),
        .hit(hit),
        .lines(lines)
    );

    prefetch_ctrl ctrl_i (
        .clk(clk),
        .reset(reset),
        .miss(miss),
        .miss_addr(miss_addr),
        .last_valid(last_valid),
        .last_served(last_served),
        .busy_miss(busy_miss),
        .busy_next(busy_next),
        .probe_miss(probe_miss),
        .probe_next(probe_next),
        .req(req)
    );

    inflight_window #(
        .MEM_LATENCY(MEM_LATENCY)
    ) window_i (
        .clk(clk),
        .reset(reset),
        .req(req),
        .probe_miss(probe_miss),
        .probe_next(probe_next),
        .busy_miss(busy_miss),
        .busy_next(busy_next)
    );

    mem_access_pipe #(
        .MEM_LATENCY(MEM_LATENCY)
    ) pipe_i (
        .clk(clk),
        .reset(reset),
        .req(req),
        .mem_read(mem_read),
        .mem_addr(mem_addr),
        .mem_line(mem_line),
        .fill(fill)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: bench/fetch_unit_chk.sv
`timescale 1ns/10ps

module fetch_unit_chk import fetch_pkg::*; #(
    parameter int LANES = 2,
    parameter int MEM_LATENCY = 2
) (
    input logic             clk,
    input logic             reset,
    input logic [LANES-1:0] order,
    input logic [LANES-1:0] done,
    input logic             mem_read,
    input line_addr_t       mem_addr
);

    localparam int win_len = MEM_LATENCY + 2;

    done_needs_order: assert property (@(posedge clk) disable iff (reset)
        (done & ~order) == '0)
        else $error("done high on a lane that has no order");

    quiet_after_reset: assert property (@(posedge clk) reset |=> !mem_read)
        else $error("mem_read high in the first cycle after reset");

    // a line stays in flight for the whole window
    for (genvar k = 1; k <= win_len; k++) begin : g_gap
        no_repeat: assert property (@(posedge clk) disable iff (reset)
            mem_read |-> !($past(mem_read, k) && $past(mem_addr, k) == mem_addr))
            else $error("line %h requested again after %0d cycles", mem_addr, k);
    end

endmodule

bind fetch_unit fetch_unit_chk #(
    .LANES(LANES),
    .MEM_LATENCY(MEM_LATENCY)
) chk_i (
    .clk(clk),
    .reset(reset),
    .order(order),
    .done(done),
    .mem_read(mem_read),
    .mem_addr(mem_addr)
);

// File: bench/fetch_unit_tb.sv
`timescale 1ns/10ps

module fetch_unit_tb import fetch_pkg::*;;

    localparam int LANES = 2;
    localparam int DEPTH = 8;
    localparam int MEM_LATENCY = 2;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES = 4;
    localparam int cold_limit = MEM_LATENCY + 4;
    localparam int serve_limit = 4 * (MEM_LATENCY + 4);
    localparam int rand_limit = 8 * (MEM_LATENCY + 4);
    localparam int N_SEQ = 32;
    localparam int RAND_CYCLES = 600;
    localparam int max_cycles = RESET_CYCLES + IDLE_CYCLES + cold_limit
        + N_SEQ * (serve_limit + 1) + serve_limit + RAND_CYCLES + rand_limit + 100;

    logic             clk;
    logic             reset;
    logic [LANES-1:0] order;
    word_t            pc [LANES];
    logic [LANES-1:0] done;
    inst_t            instr [LANES];
    logic             mem_read;
    line_addr_t       mem_addr;
    line_t            mem_line = '1;

    logic [31:0] rng_state = 32'd17631;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_passed = 0;
    int          reads_issued = 0;
    int          cycle_count = 0;

    // hist slot 0 is the previous cycle's read
    logic       hist_v [MEM_LATENCY+2] = '{default: 1'b0};
    line_addr_t hist_a [MEM_LATENCY+2] = '{default: '0};
    logic       pend_v [MEM_LATENCY] = '{default: 1'b0};
    line_addr_t pend_a [MEM_LATENCY] = '{default: '0};

    tb_clock #(
        .PERIOD_NS(10),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_i (
        .clk(clk),
        .reset(reset)
    );

    fetch_unit #(
        .LANES(LANES),
        .DEPTH(DEPTH),
        .MEM_LATENCY(MEM_LATENCY)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .order(order),
        .pc(pc),
        .done(done),
        .instr(instr),
        .mem_read(mem_read),
        .mem_addr(mem_addr),
        .mem_line(mem_line)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // instruction at word index w
    function automatic inst_t word_hash(input logic [11:0] w);
        return xorshift32(xorshift32({20'h9e377, w}));
    endfunction

    function automatic inst_t expect_instr(input word_t addr);
        return word_hash(addr[13:2]);
    endfunction

    function automatic line_t line_data(input line_addr_t a);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = word_hash({a, 2'(k)});
        end
        return l;
    endfunction

    function automatic word_t random_pc(input logic [31:0] rnd);
        return {rnd[31:14], 10'h080 + 10'(rnd[9:4]), rnd[3:2], 2'b00};
    endfunction

    // memory model: record reads, answer MEM_LATENCY cycles later
    always @(negedge clk) begin
        if (mem_read === 1'b1) begin
            reads_issued++;
            for (int k = 0; k < MEM_LATENCY + 2; k++) begin
                assert (!(hist_v[k] && hist_a[k] == mem_addr)) else begin
                    $display("line %h requested again while still in flight", mem_addr);
                    err_count++;
                end
            end
        end
        for (int k = MEM_LATENCY + 1; k > 0; k--) begin
            hist_v[k] = hist_v[k-1];
            hist_a[k] = hist_a[k-1];
        end
        hist_v[0] = (mem_read === 1'b1);
        hist_a[0] = mem_addr;
    end

    always @(posedge clk) begin
        #1;
        for (int k = MEM_LATENCY - 1; k > 0; k--) begin
            pend_v[k] = pend_v[k-1];
            pend_a[k] = pend_a[k-1];
        end
        pend_v[0] = hist_v[0];
        pend_a[0] = hist_a[0];
        if (pend_v[MEM_LATENCY-1]) begin
            mem_line = line_data(pend_a[MEM_LATENCY-1]);
        end else begin
            mem_line = '1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("timeout: run did not end within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet();
        assert (mem_read === 1'b0) else begin
            $display("error: mem_read = %h, expected 0", mem_read);
            err_count++;
        end
        assert (done === '0) else begin
            $display("error: done = %h, expected 0", done);
            err_count++;
        end
    endtask

    task automatic settle_and_check(output logic [LANES-1:0] got);
        @(negedge clk);
        got = '0;
        for (int i = 0; i < LANES; i++) begin
            assert (!(done[i] && !order[i])) else begin
                $display("lane %0d signalled done while its order was low", i);
                err_count++;
            end
            if (done[i] && order[i]) begin
                got[i] = 1'b1;
                assert (instr[i] === expect_instr(pc[i])) else begin
                    $display("error: instr[%0d] = %h, expected %h (pc %h)",
                        i, instr[i], expect_instr(pc[i]), pc[i]);
                    err_count++;
                end
            end
        end
    endtask

    // orders the lanes set in order until each is done
    task automatic wait_served(input int limit);
        logic [LANES-1:0] got;
        logic [LANES-1:0] pending;
        int n;
        pending = order;
        n = 0;
        while (pending != '0 && n < limit) begin
            settle_and_check(got);
            pending = pending & ~got;
            n++;
            next_edge();
            order = pending;
        end
        for (int i = 0; i < LANES; i++) begin
            assert (!pending[i]) else begin
                $display("lane %0d pc %h was not served within %0d cycles", i, pc[i], limit);
                err_count++;
            end
        end
        order = '0;
    endtask

    task automatic random_test();
        logic [LANES-1:0] pend;
        logic [LANES-1:0] got;
        int wait_cnt [LANES];
        int idle_cnt [LANES];
        int cyc;
        int served;
        pend = '0;
        cyc = 0;
        served = 0;
        for (int i = 0; i < LANES; i++) begin
            wait_cnt[i] = 0;
            idle_cnt[i] = 0;
        end
        while (cyc < RAND_CYCLES || (pend != '0 && cyc < RAND_CYCLES + rand_limit)) begin
            for (int i = 0; i < LANES; i++) begin
                if (!pend[i]) begin
                    pc[i] = random_pc(next_random());
                    if (idle_cnt[i] > 0) begin
                        idle_cnt[i]--;
                    end else if (cyc < RAND_CYCLES) begin
                        pend[i] = 1'b1;
                        wait_cnt[i] = 0;
                    end
                end
            end
            order = pend;
            settle_and_check(got);
            for (int i = 0; i < LANES; i++) begin
                if (pend[i] && got[i]) begin
                    pend[i] = 1'b0;
                    served++;
                    idle_cnt[i] = int'(next_random() & 32'd3);
                end else if (pend[i]) begin
                    wait_cnt[i]++;
                    assert (wait_cnt[i] < rand_limit) else begin
                        $display("lane %0d pc %h was not served within %0d cycles",
                            i, pc[i], rand_limit);
                        err_count++;
                        pend[i] = 1'b0;
                    end
                end
            end
            next_edge();
            cyc++;
        end
        assert (served > 0) else begin
            $display("random test finished without serving any order");
            err_count++;
        end
        order = '0;
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (err_count == mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, err_count - mark);
        end
    endtask

    initial begin
        int mark;
        logic [31:0] rnd;
        // lanes order during reset, nothing may be served yet
        order = '1;
        for (int i = 0; i < LANES; i++) begin
            pc[i] = '0;
        end

        mark = err_count;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_quiet();
        end
        next_edge();
        order = '0;
        repeat (IDLE_CYCLES + 1) begin
            @(negedge clk);
            check_quiet();
        end
        next_edge();
        report_test("reset", mark);

        mark = err_count;
        rnd = next_random();
        pc[0] = {rnd[31:14], 10'h040, 2'd2, 2'b00};
        order = 2'b01;
        wait_served(cold_limit);
        report_test("cold miss", mark);

        mark = err_count;
        for (int w = 0; w < N_SEQ; w++) begin
            pc[0] = 32'h0000_1000 + 32'(w * 4);
            order = 2'b01;
            wait_served(serve_limit);
        end
        report_test("sequential stream", mark);

        mark = err_count;
        pc[0] = {18'h0, 10'h200, 2'd1, 2'b00};
        pc[1] = {18'h3, 10'h2c0, 2'd3, 2'b00};
        order = 2'b11;
        wait_served(serve_limit);
        report_test("two lanes", mark);

        mark = err_count;
        random_test();
        report_test("random", mark);

        $display("%0d tests, %0d passed, %0d errors, %0d memory reads",
            tests_run, tests_passed, err_count, reads_issued);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
hw/fetch_pkg.sv
hw/lane_decode.sv
hw/line_cache.sv
hw/prefetch_ctrl.sv
hw/inflight_window.sv
hw/mem_access_pipe.sv
hw/fetch_unit.sv
bench/tb_clock.sv
bench/fetch_unit_chk.sv
bench/fetch_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fetch unit testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --Mdir obj_dir \
        --top-module fetch_unit_tb -f build.f; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/Vfetch_unit_tb); then
    echo "$output"
    echo "simulation exited with a failing status"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
